// File: src.f
+incdir+include
design/aq_pkg.sv
design/aq_ctrl.sv
design/data_prefetch.sv
design/raw_buffer.sv
design/vis_store.sv
design/aq_top.sv
test/aq_top_tb.sv

// File: run.sh
#!/bin/bash
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module aq_top_tb -o aq_sim \
   && ./obj_dir/aq_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: test/aq_testdata.txt
# S: antenna sample (hex, 24 bit)   V: visibility byte (hex)
# C: register address, value written, expected read-back (all hex)
C 6 fd 85
C 7 fe 00
C 6 02 02
C 7 01 01
S 0a0b0c
S 1d2e3f
S 123456
S abcdef
S 00ff80
S 7f0102
S c3a55a
S 918273
V 5a
V c3
V 01
V fe
V 77
V 88

// File: test/aq_top_tb.sv
`timescale 1ns/100ps
`include "aq_regs.svh"

module aq_top_tb;

   logic                        clk_i = 1'b0;
   logic                        rst_i;
   aq_pkg::bus_req_t            bus;
   logic                        ack_o;
   logic [aq_pkg::DATA_W-1:0]   dat_o;
   logic                        sample_valid_i, sample_ready_o;
   logic [aq_pkg::SAMPLE_W-1:0] sample_i;
   logic                        vis_valid_i, vis_ready_o;
   logic [aq_pkg::DATA_W-1:0]   vis_i;
   logic                        spi_busy_i;

   // Contents of the data file
   logic [23:0] samples [$];
   logic [7:0]  vis_bytes [$];
   logic [7:0]  cfg_adr [$];
   logic [7:0]  cfg_wr [$];
   logic [7:0]  cfg_exp [$];
   logic [15:0] lfsr = 16'd87;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          limit = 500;

   aq_top u_dut (
      .clk_i, .rst_i, .bus_i(bus), .ack_o, .dat_o, .sample_valid_i, .sample_ready_o,
      .sample_i, .vis_valid_i, .vis_ready_o, .vis_i, .spi_busy_i
   );

   // 8 ns clock
   always #4 clk_i = !clk_i;

   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("Timeout: the run did not complete within %0d cycles", limit);
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display("Some tests failed");
         $finish;
      end
   end

   //--------------------------------------------------
   // Helpers
   //--------------------------------------------------
   // Fibonacci LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic compare(input string name, input logic [23:0] exp, input logic [23:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      end
   endtask

   // Classic cycle with stb dropped on the edge after ack
   task automatic bus_cycle(input logic we, input logic [2:0] adr, input logic [7:0] wdat,
                            output logic [7:0] rdat);
      @(negedge clk_i);
      bus = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      @(negedge clk_i);
      while (!ack_o) @(negedge clk_i);
      rdat = dat_o;
      bus = '0;
   endtask

   task automatic reg_write(input logic [2:0] adr, input logic [7:0] wdat);
      logic [7:0] unused;
      bus_cycle(1'b1, adr, wdat, unused);
   endtask

   task automatic read_check(input string name, input logic [2:0] adr, input logic [7:0] exp);
      logic [7:0] rdat;
      bus_cycle(1'b0, adr, 8'h00, rdat);
      compare(name, exp, rdat);
   endtask

   // One LFSR bit per sample decides an idle cycle before it
   task automatic send_sample(input logic [23:0] s, output logic taken);
      int waited;
      waited = 0;
      @(negedge clk_i);
      lfsr = lfsr_next(lfsr);
      if (lfsr[0]) @(negedge clk_i);
      sample_valid_i = 1'b1;
      sample_i       = s;
      while (!sample_ready_o && waited < 12) begin
         @(negedge clk_i);
         waited++;
      end
      taken = sample_ready_o;
      @(negedge clk_i);
      sample_valid_i = 1'b0;
   endtask

   task automatic send_vis(input logic [7:0] v, output logic taken);
      int waited;
      waited = 0;
      @(negedge clk_i);
      vis_valid_i = 1'b1;
      vis_i       = v;
      while (!vis_ready_o && waited < 12) begin
         @(negedge clk_i);
         waited++;
      end
      taken = vis_ready_o;
      @(negedge clk_i);
      vis_valid_i = 1'b0;
   endtask

   task automatic load_testdata(input int fd);
      string       line;
      byte         tag;
      logic [23:0] a, b, c;
      int          n;
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         n = $sscanf(line, "%c %h %h %h", tag, a, b, c);
         if (n >= 2 && tag == "S") samples.push_back(a);
         else if (n >= 2 && tag == "V") vis_bytes.push_back(a[7:0]);
         else if (n == 4 && tag == "C") begin
            cfg_adr.push_back(a[7:0]);
            cfg_wr.push_back(b[7:0]);
            cfg_exp.push_back(c[7:0]);
         end
      end
      $fclose(fd);
      limit = 20 * (samples.size() + vis_bytes.size() + cfg_adr.size()) + 500;
   endtask

   //--------------------------------------------------
   // Test sequence
   //--------------------------------------------------
   task automatic run_tests();
      logic taken;
      int   accepted;
      repeat (3) @(negedge clk_i);
      rst_i      = 1'b0;
      spi_busy_i = 1'b1;
      // Register round trip where the last line sets delay 2 and enables
      foreach (cfg_adr[i]) begin
         reg_write(cfg_adr[i][2:0], cfg_wr[i]);
         read_check("register round trip", cfg_adr[i][2:0], cfg_exp[i]);
      end
      foreach (samples[i]) begin
         send_sample(samples[i], taken);
         compare("sample accept", 1, taken);
      end
      // First two samples skipped and bytes come high first
      for (int k = 2; k < samples.size(); k++) begin
         if (k == 2) begin
            // Direct byte reads leave the stream index alone
            read_check("ax data1", `AX_DATA1, samples[k][23:16]);
            read_check("ax data2", `AX_DATA2, samples[k][15:8]);
            read_check("ax data3", `AX_DATA3, samples[k][7:0]);
         end
         read_check("ax stream high", `AX_STREAM, samples[k][23:16]);
         read_check("ax stream middle", `AX_STREAM, samples[k][15:8]);
         if (k == 4) begin
            // SPI idle mid word restarts at the high byte
            @(negedge clk_i);
            spi_busy_i = 1'b0;
            @(negedge clk_i);
            spi_busy_i = 1'b1;
            read_check("index reset high", `AX_STREAM, samples[k][23:16]);
            read_check("index reset middle", `AX_STREAM, samples[k][15:8]);
         end
         read_check("ax stream low", `AX_STREAM, samples[k][7:0]);
      end
      // Block of 4 bytes
      reg_write(`VX_STATUS, 8'd2);
      repeat (2) @(negedge clk_i);
      for (int i = 0; i < 4; i++) begin
         send_vis(vis_bytes[i], taken);
         compare("vis accept", 1, taken);
      end
      read_check("vx status available", `VX_STATUS, {1'b1, 1'b0, 1'b1, 5'd2});
      for (int i = 0; i < 4; i++) read_check("vx stream", `VX_STREAM, vis_bytes[i]);
      read_check("vx status accessed", `VX_STATUS, {1'b0, 1'b1, 1'b1, 5'd2});
      read_check("block count", `AQ_STATUS, {5'd1, 2'b00, 1'b1});
      // log_block 7 clamps to 64 bytes
      reg_write(`VX_STATUS, 8'd7);
      repeat (2) @(negedge clk_i);
      for (int i = 0; i < 64; i++) begin
         if (i == 63) read_check("clamp partial", `VX_STATUS, {1'b0, 1'b1, 1'b1, 5'd7});
         send_vis(vis_bytes[i % vis_bytes.size()], taken);
         compare("vis accept", 1, taken);
      end
      read_check("clamp full", `VX_STATUS, {1'b1, 1'b0, 1'b1, 5'd7});
      for (int i = 0; i < 64; i++) begin
         read_check("clamp stream", `VX_STREAM, vis_bytes[i % vis_bytes.size()]);
      end
      read_check("block count", `AQ_STATUS, {5'd2, 2'b00, 1'b1});
      // Re-enable so the skip reloads before the back-pressure run
      reg_write(`AQ_STATUS, 8'h00);
      reg_write(`AQ_STATUS, 8'h01);
      accepted = 0;
      taken    = 1'b1;
      while (taken && accepted < 40) begin
         send_sample(samples[accepted % samples.size()], taken);
         if (taken) accepted++;
      end
      compare("back-pressure", 2 + aq_pkg::FIFO_DEPTH + 1, accepted);
   endtask

   initial begin
      int fd;
      bus            = '0;
      rst_i          = 1'b1;
      sample_valid_i = 1'b0;
      sample_i       = '0;
      vis_valid_i    = 1'b0;
      vis_i          = '0;
      spi_busy_i     = 1'b0;
      fd = $fopen("test/aq_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the data file test/aq_testdata.txt");
         errors++;
      end else begin
         load_testdata(fd);
         run_tests();
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: design/aq_top.sv
`timescale 1ns/100ps

module aq_top (
   input  logic                        clk_i,
   input  logic                        rst_i,
   // Register port
   input  aq_pkg::bus_req_t            bus_i,
   output logic                        ack_o,
   output logic [aq_pkg::DATA_W-1:0]   dat_o,
   // Antenna samples
   input  logic                        sample_valid_i,
   output logic                        sample_ready_o,
   input  logic [aq_pkg::SAMPLE_W-1:0] sample_i,
   // Visibility bytes
   input  logic                        vis_valid_i,
   output logic                        vis_ready_o,
   input  logic [aq_pkg::DATA_W-1:0]   vis_i,
   input  logic                        spi_busy_i
);

   aq_pkg::aq_cfg_t                 cfg;
   logic                            buf_valid, buf_ready, data_sent;
   logic [aq_pkg::SAMPLE_W-1:0]     buf_data, fetched_data;
   logic                            vx_stb, vx_ack, newblock, streamed;
   logic [aq_pkg::BLOCK_BITS-1:0]   vx_blk;
   logic [aq_pkg::DATA_W-1:0]       vx_dat;
   logic [aq_pkg::ACCUM_W-1:0]      blocksize;

   aq_ctrl u_ctrl (
      .clk_i, .rst_i, .bus_i, .ack_o, .dat_o,
      .fetched_data_i(fetched_data), .data_sent_o(data_sent), .spi_busy_i,
      .vx_stb_o(vx_stb), .vx_blk_o(vx_blk), .blocksize_o(blocksize),
      .vx_ack_i(vx_ack), .vx_dat_i(vx_dat), .newblock_i(newblock),
      .streamed_i(streamed), .cfg_o(cfg)
   );

   // Sample path: buffer then one-word prefetch
   raw_buffer u_raw (
      .clk_i, .rst_i, .cfg_i(cfg), .sample_valid_i, .sample_ready_o, .sample_i,
      .buf_valid_o(buf_valid), .buf_ready_i(buf_ready), .buf_data_o(buf_data)
   );

   data_prefetch u_prefetch (
      .clk_i, .rst_i, .buf_valid_i(buf_valid), .buf_ready_o(buf_ready),
      .buf_data_i(buf_data), .data_sent_i(data_sent), .fetched_data_o(fetched_data)
   );

   vis_store u_vis (
      .clk_i, .rst_i, .blocksize_i(blocksize), .vis_valid_i, .vis_ready_o, .vis_i,
      .vx_stb_i(vx_stb), .vx_blk_i(vx_blk), .vx_ack_o(vx_ack), .vx_dat_o(vx_dat),
      .newblock_o(newblock), .streamed_o(streamed)
   );

endmodule

// File: design/vis_store.sv
`timescale 1ns/100ps

module vis_store (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic [aq_pkg::ACCUM_W-1:0]    blocksize_i,
   // Visibility bytes in
   input  logic                          vis_valid_i,
   output logic                          vis_ready_o,
   input  logic [aq_pkg::DATA_W-1:0]     vis_i,
   // Block read port
   input  logic                          vx_stb_i,
   input  logic [aq_pkg::BLOCK_BITS-1:0] vx_blk_i,
   output logic                          vx_ack_o,
   output logic [aq_pkg::DATA_W-1:0]     vx_dat_o,
   output logic                          newblock_o,
   output logic                          streamed_o
);

   // Bank select is the top address bit
   logic [aq_pkg::DATA_W-1:0]                mem [2**(aq_pkg::MAX_LOG_BLOCK+1)];
   logic [1:0][aq_pkg::MAX_LOG_BLOCK-1:0]    wr_ptr_q, rd_ptr_q;
   logic [1:0]                               full_q;
   logic                                     wbank_q, rbank;
   logic                                     accept, rd_go, wr_last, rd_last;

   assign rbank       = vx_blk_i[0];
   assign vis_ready_o = !full_q[wbank_q];
   assign accept      = vis_valid_i && vis_ready_o;
   // One read per strobe, none while acking
   assign rd_go       = vx_stb_i && !vx_ack_o;
   assign wr_last = blocksize_i == aq_pkg::ACCUM_W'(wr_ptr_q[wbank_q]);
   assign rd_last = blocksize_i == aq_pkg::ACCUM_W'(rd_ptr_q[rbank]);

   always_ff @(posedge clk_i) begin
      if (accept) mem[{wbank_q, wr_ptr_q[wbank_q]}] <= vis_i;
      if (rd_go)  vx_dat_o <= mem[{rbank, rd_ptr_q[rbank]}];
   end

   //------------------------------------------------
   // Block fill and drain tracking
   //------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         full_q     <= '0;
         wbank_q    <= 1'b0;
         vx_ack_o   <= 1'b0;
         newblock_o <= 1'b0;
         streamed_o <= 1'b0;
      end else begin
         vx_ack_o   <= rd_go;
         newblock_o <= accept && wr_last;
         streamed_o <= rd_go && full_q[rbank] && rd_last;
         if (accept) begin
            if (wr_last) begin
               // Bank complete, swap to the other one
               wr_ptr_q[wbank_q] <= '0;
               full_q[wbank_q]   <= 1'b1;
               wbank_q           <= !wbank_q;
            end else begin
               wr_ptr_q[wbank_q] <= wr_ptr_q[wbank_q] + 1'b1;
            end
         end
         // Reads of an unfilled bank do not advance
         if (rd_go && full_q[rbank]) begin
            if (rd_last) begin
               rd_ptr_q[rbank] <= '0;
               full_q[rbank]   <= 1'b0;
            end else begin
               rd_ptr_q[rbank] <= rd_ptr_q[rbank] + 1'b1;
            end
         end
      end
   end

endmodule

// File: design/raw_buffer.sv
`timescale 1ns/100ps

module raw_buffer (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  aq_pkg::aq_cfg_t             cfg_i,
   // Antenna samples in
   input  logic                        sample_valid_i,
   output logic                        sample_ready_o,
   input  logic [aq_pkg::SAMPLE_W-1:0] sample_i,
   // Samples out to the prefetcher
   output logic                        buf_valid_o,
   input  logic                        buf_ready_i,
   output logic [aq_pkg::SAMPLE_W-1:0] buf_data_o
);

   logic [aq_pkg::SAMPLE_W-1:0]          mem [aq_pkg::FIFO_DEPTH];
   logic [$clog2(aq_pkg::FIFO_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
   logic [$clog2(aq_pkg::FIFO_DEPTH):0]   count_q;
   logic                                  en_q, en_rise;
   logic [2:0]                            skip_q, skip_now;
   logic                                  accept, push, pop;

   //------------------------------------------------
   // Start-up skip
   //------------------------------------------------
   assign en_rise  = cfg_i.enabled && !en_q;
   // Delay applies already in the enabling cycle
   assign skip_now = en_rise ? cfg_i.sample_delay : skip_q;

   assign sample_ready_o = cfg_i.enabled && count_q != aq_pkg::FIFO_DEPTH;
   assign accept         = sample_valid_i && sample_ready_o;
   assign push           = accept && skip_now == 3'd0;
   assign pop            = buf_valid_o && buf_ready_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         en_q   <= 1'b0;
         skip_q <= 3'd0;
      end else begin
         en_q <= cfg_i.enabled;
         if (accept && skip_now != 3'd0) begin
            skip_q <= skip_now - 3'd1;
         end else begin
            skip_q <= skip_now;
         end
      end
   end

   //------------------------------------------------
   // Sample FIFO
   //------------------------------------------------
   assign buf_valid_o = count_q != '0;
   assign buf_data_o  = mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr_q] <= sample_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
         if (push && !pop)      count_q <= count_q + 1'b1;
         else if (pop && !push) count_q <= count_q - 1'b1;
      end
   end

endmodule

// File: design/data_prefetch.sv
`timescale 1ns/100ps

module data_prefetch (
   input  logic                        clk_i,
   input  logic                        rst_i,
   // Sample stream from the raw buffer
   input  logic                        buf_valid_i,
   output logic                        buf_ready_o,
   input  logic [aq_pkg::SAMPLE_W-1:0] buf_data_i,
   // Word release from the register bank
   input  logic                        data_sent_i,
   output logic [aq_pkg::SAMPLE_W-1:0] fetched_data_o
);

   logic                        full_q;
   logic [aq_pkg::SAMPLE_W-1:0] data_q;
   logic                        take;

   // Free slot, or slot freed this cycle
   assign buf_ready_o    = !full_q || data_sent_i;
   assign take           = buf_valid_i && buf_ready_o;
   assign fetched_data_o = data_q;

   //------------------------------------------------
   // Holding register
   //------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         full_q <= 1'b0;
      end else if (take) begin
         full_q <= 1'b1;
      end else if (data_sent_i) begin
         full_q <= 1'b0;
      end
   end

   // Old word stays visible until replaced
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         data_q <= '0;
      end else if (take) begin
         data_q <= buf_data_i;
      end
   end

endmodule

// File: design/aq_ctrl.sv
`timescale 1ns/100ps
`include "aq_regs.svh"

module aq_ctrl (
   input  logic                          clk_i,
   input  logic                          rst_i,
   // Register port
   input  aq_pkg::bus_req_t              bus_i,
   output logic                          ack_o,
   output logic [aq_pkg::DATA_W-1:0]     dat_o,
   // Prefetched antenna word
   input  logic [aq_pkg::SAMPLE_W-1:0]   fetched_data_i,
   output logic                          data_sent_o,
   input  logic                          spi_busy_i,
   // Visibility store
   output logic                          vx_stb_o,
   output logic [aq_pkg::BLOCK_BITS-1:0] vx_blk_o,
   output logic [aq_pkg::ACCUM_W-1:0]    blocksize_o,
   input  logic                          vx_ack_i,
   input  logic [aq_pkg::DATA_W-1:0]     vx_dat_i,
   input  logic                          newblock_i,
   input  logic                          streamed_i,
   output aq_pkg::aq_cfg_t               cfg_o
);

   aq_pkg::aq_cfg_t               cfg_q;
   logic                          bus_req, rd_req, wr_req;
   logic                          x_ack, send, wrap_index, bs_new;
   logic                          available_q, accessed_q;
   logic                          bs_upd_q, bs_dec_q;
   logic [2:0]                    bs_log_q;
   logic [1:0]                    index_q;
   logic [aq_pkg::DATA_W-1:0]     ax_byte, vx_status, aq_debug, aq_status;

   // New request, not yet acknowledged
   assign bus_req = bus_i.cyc && bus_i.stb && !ack_o;
   assign rd_req  = bus_req && !bus_i.we;
   assign wr_req  = bus_req && bus_i.we;

   assign x_ack    = rd_req && bus_i.adr == `VX_STREAM && vx_ack_i;
   assign vx_stb_o = rd_req && bus_i.adr == `VX_STREAM;
   assign send     = rd_req && bus_i.adr == `AX_STREAM;
   assign bs_new   = wr_req && bus_i.adr == `VX_STATUS;
   assign cfg_o    = cfg_q;

   // Read-back layouts
   assign vx_status = {available_q, accessed_q, cfg_q.enabled, cfg_q.log_block};
   // Debug flag in bit 7, delay in bits 2:0
   assign aq_debug  = {cfg_q.debug_mode, 4'b0000, cfg_q.sample_delay};
   assign aq_status = {vx_blk_o, 2'b00, cfg_q.enabled};

   //------------------------------------------------
   // Register port
   //------------------------------------------------
   // Visibility reads wait for the store's ack
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
      end else if (rd_req && bus_i.adr == `VX_STREAM) begin
         ack_o <= vx_ack_i;
      end else begin
         ack_o <= bus_req;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_req) begin
         case (bus_i.adr)
            `AX_STREAM: dat_o <= ax_byte;
            `AX_DATA1:  dat_o <= fetched_data_i[23:16];
            `AX_DATA2:  dat_o <= fetched_data_i[15:8];
            `AX_DATA3:  dat_o <= fetched_data_i[7:0];
            `VX_STREAM: dat_o <= vx_dat_i;
            `VX_STATUS: dat_o <= vx_status;
            `AQ_DEBUG:  dat_o <= aq_debug;
            `AQ_STATUS: dat_o <= aq_status;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cfg_q <= '0;
      end else if (wr_req) begin
         case (bus_i.adr)
            `VX_STATUS: cfg_q.log_block <= bus_i.dat[4:0];
            `AQ_DEBUG: begin
               cfg_q.debug_mode   <= bus_i.dat[7];
               cfg_q.sample_delay <= bus_i.dat[2:0];
            end
            `AQ_STATUS: cfg_q.enabled <= bus_i.dat[0];
            default: ;
         endcase
      end
   end

   //------------------------------------------------
   // Visibility block control
   //------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         available_q <= 1'b0;
         accessed_q  <= 1'b0;
      end else if (newblock_i) begin
         available_q <= 1'b1;
         accessed_q  <= 1'b0;
      end else if (x_ack) begin
         available_q <= 1'b0;
         accessed_q  <= 1'b1;
      end
   end

   // Stage one clamps, stage two expands to 2^n - 1
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bs_upd_q    <= 1'b0;
         bs_dec_q    <= 1'b0;
         bs_log_q    <= '0;
         blocksize_o <= '0;
      end else begin
         bs_upd_q <= bs_new;
         bs_dec_q <= bs_upd_q;
         if (bs_upd_q) begin
            if (cfg_q.log_block > aq_pkg::MAX_LOG_BLOCK) begin
               bs_log_q <= 3'(aq_pkg::MAX_LOG_BLOCK);
            end else begin
               bs_log_q <= cfg_q.log_block[2:0];
            end
         end
         if (bs_dec_q) begin
            blocksize_o <= ~('1 << bs_log_q);
         end
      end
   end

   // Block counter steps once the current block is drained
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         vx_blk_o <= '0;
      end else if (streamed_i) begin
         vx_blk_o <= vx_blk_o + 1'b1;
      end
   end

   //------------------------------------------------
   // Antenna byte index
   //------------------------------------------------
   assign wrap_index = index_q == 2'd2;

   always_comb begin
      case (index_q)
         2'd0:    ax_byte = fetched_data_i[23:16];
         2'd1:    ax_byte = fetched_data_i[15:8];
         default: ax_byte = fetched_data_i[7:0];
      endcase
   end

   // Index restarts whenever the SPI host goes idle
   always_ff @(posedge clk_i) begin
      if (rst_i || !spi_busy_i) begin
         index_q <= 2'd0;
      end else if (send) begin
         index_q <= wrap_index ? 2'd0 : index_q + 2'd1;
      end
   end

   // Last byte gone, release the held word
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         data_sent_o <= 1'b0;
      end else begin
         data_sent_o <= send && wrap_index;
      end
   end

endmodule

// File: design/aq_pkg.sv
package aq_pkg;

   // Bus and sample widths
   localparam int DATA_W        = 8;
   localparam int SAMPLE_W      = 24;
   localparam int BLOCK_BITS    = 5;
   localparam int ACCUM_W       = 32;
   // Visibility store is 2^6 bytes per bank
   localparam int MAX_LOG_BLOCK = 6;
   localparam int FIFO_DEPTH    = 16;

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [2:0]        adr;
      logic [DATA_W-1:0] dat;
   } bus_req_t;

   typedef struct packed {
      logic       enabled;
      logic       debug_mode;
      logic [2:0] sample_delay;
      logic [4:0] log_block;
   } aq_cfg_t;

endpackage

// File: include/aq_regs.svh
`ifndef AQ_REGS_SVH
`define AQ_REGS_SVH

// Raw antenna sample read-back
`define AX_STREAM 3'h0
`define AX_DATA1  3'h1
`define AX_DATA2  3'h2
`define AX_DATA3  3'h3

// Visibility access and block size
`define VX_STREAM 3'h4
`define VX_STATUS 3'h5

// Acquisition debug, status and control
`define AQ_DEBUG  3'h6
`define AQ_STATUS 3'h7

`endif
